// ==== include/arcade_input_defines.svh ====
// Shared constants for the arcade player-control front end.
// Include in any RTL or testbench file that needs player counts,
// joystick bit positions, PS/2 scancodes or the DIP download index.
`ifndef ARCADE_INPUT_DEFINES_SVH
`define ARCADE_INPUT_DEFINES_SVH

`define NUM_PLAYERS         4

// Joystick word bit positions
`define JOY_START_BIT       10
`define JOY_COIN_BIT        11
`define JOY_START2_ALT_BIT  12
`define JOY_PAUSE_BIT       13

// DIP switch download
`define DIP_INDEX           8'd254
`define NUM_DIP_BYTES       3

// PS/2 set 2 scancodes
// Arrows are extended (E0 prefix)
`define SC_UP               8'h75
`define SC_DOWN             8'h72
`define SC_LEFT             8'h6b
`define SC_RIGHT            8'h74
`define SC_LCTRL            8'h14
`define SC_LALT             8'h11
`define SC_R                8'h2d
`define SC_F                8'h2b
`define SC_D                8'h23
`define SC_G                8'h34
`define SC_A                8'h1c
`define SC_S                8'h1b
`define SC_1                8'h16
`define SC_2                8'h1e
`define SC_3                8'h26
`define SC_4                8'h25
`define SC_5                8'h2e
`define SC_6                8'h36
`define SC_7                8'h3d
`define SC_8                8'h3e
`define SC_P                8'h4d

`endif

// ==== src/arcade_input_pkg.sv ====
// Vector types shared by the input front end RTL and its testbench.
// Refer to them with scoped names, e.g. arcade_input_pkg::joy_word_t.
package arcade_input_pkg;

    // {toggle, pressed, extended, scancode[7:0]}
    typedef logic [10:0] ps2_key_t;

    // One joystick word from the host
    typedef logic [15:0] joy_word_t;

    // Bits 0..3 right, left, down, up; bits 4..9 buttons
    typedef logic [9:0]  player_ctrl_t;

    // 0..9 control bit, 10 start, 11 coin
    typedef logic [3:0]  key_func_t;

    typedef logic [1:0]  player_idx_t;

    typedef logic [7:0]  dip_byte_t;

    // Byte 2 in the top bits, byte 0 in the bottom bits
    typedef logic [23:0] dip_bank_t;

endpackage

// ==== src/ps2_key_decoder.sv ====
// Turns PS/2 key events into per-player key strobes.
// A new event is seen when the toggle bit flips; mapped keys give one
// key_valid strobe, a press of P gives one pause_key pulse instead.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module ps2_key_decoder (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  arcade_input_pkg::ps2_key_t    ps2_key,
    output logic                          key_valid,
    output arcade_input_pkg::player_idx_t key_player,
    output arcade_input_pkg::key_func_t   key_func,
    output logic                          key_pressed,
    output logic                          pause_key
);

    arcade_input_pkg::ps2_key_t key_q;
    logic                       tog_q;
    logic                       new_evt;
    // {hit, pause, player[1:0], func[3:0]}
    logic [7:0]                 map_ent;

    assign new_evt = key_q[10] ^ tog_q;

    //////////////////////////////////////////////////
    // Scancode table
    //////////////////////////////////////////////////
    always_comb begin
        case ({key_q[8], key_q[7:0]})
            {1'b1, `SC_RIGHT}: map_ent = {2'b10, 2'd0, 4'd0};
            {1'b1, `SC_LEFT}:  map_ent = {2'b10, 2'd0, 4'd1};
            {1'b1, `SC_DOWN}:  map_ent = {2'b10, 2'd0, 4'd2};
            {1'b1, `SC_UP}:    map_ent = {2'b10, 2'd0, 4'd3};
            {1'b0, `SC_LCTRL}: map_ent = {2'b10, 2'd0, 4'd4};
            {1'b0, `SC_LALT}:  map_ent = {2'b10, 2'd0, 4'd5};
            // Player 2 on the left hand side of the keyboard
            {1'b0, `SC_G}:     map_ent = {2'b10, 2'd1, 4'd0};
            {1'b0, `SC_D}:     map_ent = {2'b10, 2'd1, 4'd1};
            {1'b0, `SC_F}:     map_ent = {2'b10, 2'd1, 4'd2};
            {1'b0, `SC_R}:     map_ent = {2'b10, 2'd1, 4'd3};
            {1'b0, `SC_A}:     map_ent = {2'b10, 2'd1, 4'd4};
            {1'b0, `SC_S}:     map_ent = {2'b10, 2'd1, 4'd5};
            // Start keys
            {1'b0, `SC_1}:     map_ent = {2'b10, 2'd0, 4'd10};
            {1'b0, `SC_2}:     map_ent = {2'b10, 2'd1, 4'd10};
            {1'b0, `SC_3}:     map_ent = {2'b10, 2'd2, 4'd10};
            {1'b0, `SC_4}:     map_ent = {2'b10, 2'd3, 4'd10};
            // Coin keys
            {1'b0, `SC_5}:     map_ent = {2'b10, 2'd0, 4'd11};
            {1'b0, `SC_6}:     map_ent = {2'b10, 2'd1, 4'd11};
            {1'b0, `SC_7}:     map_ent = {2'b10, 2'd2, 4'd11};
            {1'b0, `SC_8}:     map_ent = {2'b10, 2'd3, 4'd11};
            {1'b0, `SC_P}:     map_ent = {2'b11, 2'd0, 4'd0};
            default:           map_ent = 8'h00;
        endcase
    end

    //////////////////////////////////////////////////
    // Event detection and strobes
    //////////////////////////////////////////////////
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            key_q     <= '0;
            tog_q     <= 1'b0;
            key_valid <= 1'b0;
            pause_key <= 1'b0;
        end else begin
            key_q     <= ps2_key;
            tog_q     <= key_q[10];
            key_valid <= new_evt & map_ent[7] & ~map_ent[6];
            // Only the press of P counts
            pause_key <= new_evt & map_ent[7] & map_ent[6] & key_q[9];
        end
    end

    // Event payload, qualified by key_valid downstream
    always_ff @(posedge clk_sys) begin
        if (new_evt) begin
            key_player  <= map_ent[5:4];
            key_func    <= map_ent[3:0];
            key_pressed <= key_q[9];
        end
    end

endmodule

// ==== src/player_input_slice.sv ====
// One player's input slice. Tracks that player's keyboard keys and
// merges them with the player's joystick word into registered outputs.
// PLAYER selects which key events from the decoder belong here.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module player_input_slice #(
    parameter int PLAYER = 0
) (
    input  logic                           clk_sys,
    input  logic                           rst_n,
    input  logic                           key_valid,
    input  arcade_input_pkg::player_idx_t  key_player,
    input  arcade_input_pkg::key_func_t    key_func,
    input  logic                           key_pressed,
    input  arcade_input_pkg::joy_word_t    joystick,
    output arcade_input_pkg::player_ctrl_t controls,
    output logic                           start_req,
    output logic                           coin_req,
    output logic                           alt_start,
    output logic                           pause_btn
);

    // Ten controls, then start (10) and coin (11)
    logic [11:0] kb_bits;
    logic [11:0] kb_next;

    always_comb begin
        kb_next = kb_bits;
        if (key_valid && key_player == arcade_input_pkg::player_idx_t'(PLAYER)
                && key_func < 4'd12) begin
            kb_next[key_func] = key_pressed;
        end
    end

    // Outputs use the next keyboard state so a key shows one cycle after its strobe
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            kb_bits   <= '0;
            controls  <= '0;
            start_req <= 1'b0;
            coin_req  <= 1'b0;
            alt_start <= 1'b0;
            pause_btn <= 1'b0;
        end else begin
            kb_bits   <= kb_next;
            controls  <= kb_next[9:0] | joystick[9:0];
            start_req <= kb_next[10] | joystick[`JOY_START_BIT];
            coin_req  <= kb_next[11] | joystick[`JOY_COIN_BIT];
            alt_start <= joystick[`JOY_START2_ALT_BIT];
            pause_btn <= joystick[`JOY_PAUSE_BIT];
        end
    end

endmodule

// ==== src/control_collector.sv ====
// Gathers start, coin and pause from all player slices.
// Start 2 also fires from the alternate start bit of any joystick.
// Pause toggles on each rising edge of the combined pause level and is
// forced on while the OSD is open if the OSD pause option is set.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module control_collector (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic [`NUM_PLAYERS-1:0] start_req,
    input  logic [`NUM_PLAYERS-1:0] coin_req,
    input  logic [`NUM_PLAYERS-1:0] alt_start,
    input  logic [`NUM_PLAYERS-1:0] pause_btn,
    input  logic                    pause_key,
    input  logic                    osd_pause_en,
    input  logic                    osd_status,
    output logic [`NUM_PLAYERS-1:0] start,
    output logic [`NUM_PLAYERS-1:0] coin,
    output logic                    pause_cpu
);

    logic [`NUM_PLAYERS-1:0] start_next;
    logic                    pause_lvl;
    logic                    pause_prev;
    logic                    pause_tog;

    //////////////////////////////////////////////////
    // Start and coin
    //////////////////////////////////////////////////
    always_comb begin
        start_next    = start_req;
        // Shared start 2 alias
        start_next[1] = start_req[1] | (|alt_start);
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            start <= '0;
            coin  <= '0;
        end else begin
            start <= start_next;
            coin  <= coin_req;
        end
    end

    //////////////////////////////////////////////////
    // Pause toggle
    //////////////////////////////////////////////////
    assign pause_lvl = (|pause_btn) | pause_key;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pause_prev <= 1'b0;
            pause_tog  <= 1'b0;
        end else begin
            pause_prev <= pause_lvl;
            if (pause_lvl && !pause_prev) begin
                pause_tog <= ~pause_tog;
            end
        end
    end

    assign pause_cpu = pause_tog | (osd_pause_en & osd_status);

endmodule

// ==== src/dip_switch_bank.sv ====
// DIP switch bytes loaded through the download port.
// Bytes reset to all ones since the switches are active low; only the
// bytes the core uses are kept, higher addresses are dropped.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module dip_switch_bank (
    input  logic                        clk_sys,
    input  logic                        rst_n,
    input  logic                        ioctl_wr,
    input  logic [7:0]                  ioctl_index,
    input  logic [24:0]                 ioctl_addr,
    input  arcade_input_pkg::dip_byte_t ioctl_dout,
    output arcade_input_pkg::dip_bank_t dip_sw
);

    logic dip_wr;

    assign dip_wr = ioctl_wr && (ioctl_index == `DIP_INDEX);

    genvar i;
    generate
        for (i = 0; i < `NUM_DIP_BYTES; i++) begin : g_byte
            arcade_input_pkg::dip_byte_t dip_q;

            always_ff @(posedge clk_sys or negedge rst_n) begin
                if (!rst_n) begin
                    dip_q <= 8'hff;
                end else if (dip_wr && ioctl_addr == 25'(i)) begin
                    dip_q <= ioctl_dout;
                end
            end

            // Byte 0 lands in the low bits
            assign dip_sw[8*i +: 8] = dip_q;
        end
    endgenerate

endmodule

// ==== src/arcade_input_top.sv ====
// Player-control front end of the arcade core.
// PS/2 decoder feeds four player slices, the collector builds start,
// coin and pause, and the DIP bank sits alongside on the download port.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module arcade_input_top (
    input  logic                           clk_sys,
    input  logic                           rst_n,
    input  arcade_input_pkg::ps2_key_t     ps2_key,
    input  arcade_input_pkg::joy_word_t    joystick_p1,
    input  arcade_input_pkg::joy_word_t    joystick_p2,
    input  arcade_input_pkg::joy_word_t    joystick_p3,
    input  arcade_input_pkg::joy_word_t    joystick_p4,
    input  logic                           osd_pause_en,
    input  logic                           osd_status,
    input  logic                           ioctl_wr,
    input  logic [7:0]                     ioctl_index,
    input  logic [24:0]                    ioctl_addr,
    input  arcade_input_pkg::dip_byte_t    ioctl_dout,
    output arcade_input_pkg::player_ctrl_t controls_p1,
    output arcade_input_pkg::player_ctrl_t controls_p2,
    output arcade_input_pkg::player_ctrl_t controls_p3,
    output arcade_input_pkg::player_ctrl_t controls_p4,
    output logic [`NUM_PLAYERS-1:0]        start,
    output logic [`NUM_PLAYERS-1:0]        coin,
    output logic                           pause_cpu,
    output arcade_input_pkg::dip_bank_t    dip_sw
);

    logic                           key_valid;
    arcade_input_pkg::player_idx_t  key_player;
    arcade_input_pkg::key_func_t    key_func;
    logic                           key_pressed;
    logic                           pause_key;

    arcade_input_pkg::joy_word_t    joy [`NUM_PLAYERS];
    arcade_input_pkg::player_ctrl_t ctrl [`NUM_PLAYERS];
    logic [`NUM_PLAYERS-1:0]        start_req;
    logic [`NUM_PLAYERS-1:0]        coin_req;
    logic [`NUM_PLAYERS-1:0]        alt_start;
    logic [`NUM_PLAYERS-1:0]        pause_btn;

    assign joy[0] = joystick_p1;
    assign joy[1] = joystick_p2;
    assign joy[2] = joystick_p3;
    assign joy[3] = joystick_p4;

    assign controls_p1 = ctrl[0];
    assign controls_p2 = ctrl[1];
    assign controls_p3 = ctrl[2];
    assign controls_p4 = ctrl[3];

    ps2_key_decoder u_ps2_key_decoder (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ps2_key     (ps2_key),
        .key_valid   (key_valid),
        .key_player  (key_player),
        .key_func    (key_func),
        .key_pressed (key_pressed),
        .pause_key   (pause_key)
    );

    //////////////////////////////////////////////////
    // Player slices
    //////////////////////////////////////////////////
    genvar p;
    generate
        for (p = 0; p < `NUM_PLAYERS; p++) begin : g_player
            player_input_slice #(
                .PLAYER (p)
            ) u_player_input_slice (
                .clk_sys     (clk_sys),
                .rst_n       (rst_n),
                .key_valid   (key_valid),
                .key_player  (key_player),
                .key_func    (key_func),
                .key_pressed (key_pressed),
                .joystick    (joy[p]),
                .controls    (ctrl[p]),
                .start_req   (start_req[p]),
                .coin_req    (coin_req[p]),
                .alt_start   (alt_start[p]),
                .pause_btn   (pause_btn[p])
            );
        end
    endgenerate

    control_collector u_control_collector (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .start_req    (start_req),
        .coin_req     (coin_req),
        .alt_start    (alt_start),
        .pause_btn    (pause_btn),
        .pause_key    (pause_key),
        .osd_pause_en (osd_pause_en),
        .osd_status   (osd_status),
        .start        (start),
        .coin         (coin),
        .pause_cpu    (pause_cpu)
    );

    dip_switch_bank u_dip_switch_bank (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .dip_sw      (dip_sw)
    );

endmodule

// ==== verif/arcade_input_assert.sv ====
// Concurrent checks on the ports of the input front end top level.
// Bound into every arcade_input_top instance by the bind at the bottom.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module arcade_input_assert (
    input logic                           clk_sys,
    input logic                           rst_n,
    input arcade_input_pkg::ps2_key_t     ps2_key,
    input arcade_input_pkg::joy_word_t    joystick_p1,
    input arcade_input_pkg::joy_word_t    joystick_p2,
    input arcade_input_pkg::joy_word_t    joystick_p3,
    input arcade_input_pkg::joy_word_t    joystick_p4,
    input logic                           osd_pause_en,
    input logic                           osd_status,
    input logic                           ioctl_wr,
    input logic [7:0]                     ioctl_index,
    input logic [24:0]                    ioctl_addr,
    input arcade_input_pkg::player_ctrl_t controls_p1,
    input arcade_input_pkg::player_ctrl_t controls_p2,
    input arcade_input_pkg::player_ctrl_t controls_p3,
    input arcade_input_pkg::player_ctrl_t controls_p4,
    input logic [`NUM_PLAYERS-1:0]        start,
    input logic [`NUM_PLAYERS-1:0]        coin,
    input logic                           pause_cpu,
    input arcade_input_pkg::dip_bank_t    dip_sw
);

    // Number of failed assertions
    int         fail_cnt = 0;
    logic [3:0] pause_bits;
    logic [3:0] pause_bits_q;
    logic       key_tog_q;
    logic [1:0] osd_q;
    logic       pause_src;
    logic [2:0] src_hist;
    logic       dip_wr_ok;

    assign pause_bits = {joystick_p4[`JOY_PAUSE_BIT], joystick_p3[`JOY_PAUSE_BIT],
                         joystick_p2[`JOY_PAUSE_BIT], joystick_p1[`JOY_PAUSE_BIT]};

    // New press of P, a rising joystick pause bit or a change on the OSD lines
    assign pause_src = ((ps2_key[10] != key_tog_q) && ps2_key[9] && !ps2_key[8]
                        && ps2_key[7:0] == `SC_P)
                       || (|(pause_bits & ~pause_bits_q))
                       || ({osd_pause_en, osd_status} != osd_q);

    assign dip_wr_ok = ioctl_wr && ioctl_index == `DIP_INDEX && ioctl_addr < `NUM_DIP_BYTES;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            key_tog_q    <= 1'b0;
            pause_bits_q <= '0;
            osd_q        <= '0;
            src_hist     <= '0;
        end else begin
            key_tog_q    <= ps2_key[10];
            pause_bits_q <= pause_bits;
            osd_q        <= {osd_pause_en, osd_status};
            src_hist     <= {src_hist[1:0], pause_src};
        end
    end

    //////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////
    reset_values: assert property (@(posedge clk_sys) $rose(rst_n) |->
        (controls_p1 == '0 && controls_p2 == '0 && controls_p3 == '0 && controls_p4 == '0
         && start == '0 && coin == '0 && !pause_cpu && dip_sw == '1))
    else begin
        fail_cnt++;
        $error("Outputs were not at their reset values when reset was released");
    end

    // Pause moves at most 3 cycles after one of its sources
    pause_has_source: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $changed(pause_cpu) |-> (pause_src || (|src_hist)))
    else begin
        fail_cnt++;
        $error("pause_cpu changed with no pause event or OSD change shortly before");
    end

    dip_needs_write: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $changed(dip_sw) |-> $past(dip_wr_ok))
    else begin
        fail_cnt++;
        $error("dip_sw changed without a DIP download write the cycle before");
    end

endmodule

bind arcade_input_top arcade_input_assert u_arcade_input_assert (.*);

// ==== verif/arcade_input_tb.sv ====
// Testbench for the arcade player-control front end.
// Drives joystick words, PS/2 events, the OSD lines and download writes,
// and compares all outputs with a model of the port rules.
`timescale 1ns/100ps
`include "arcade_input_defines.svh"

module arcade_input_tb;

    localparam int MAX_CYCLES = 3000;

    // {extended, player[1:0], func[3:0], scancode[7:0]}
    localparam logic [14:0] KEY_MAP [20] = '{
        {1'b1, 2'd0, 4'd0, `SC_RIGHT},  {1'b1, 2'd0, 4'd1, `SC_LEFT},
        {1'b1, 2'd0, 4'd2, `SC_DOWN},   {1'b1, 2'd0, 4'd3, `SC_UP},
        {1'b0, 2'd0, 4'd4, `SC_LCTRL},  {1'b0, 2'd0, 4'd5, `SC_LALT},
        {1'b0, 2'd1, 4'd0, `SC_G},      {1'b0, 2'd1, 4'd1, `SC_D},
        {1'b0, 2'd1, 4'd2, `SC_F},      {1'b0, 2'd1, 4'd3, `SC_R},
        {1'b0, 2'd1, 4'd4, `SC_A},      {1'b0, 2'd1, 4'd5, `SC_S},
        {1'b0, 2'd0, 4'd10, `SC_1},     {1'b0, 2'd1, 4'd10, `SC_2},
        {1'b0, 2'd2, 4'd10, `SC_3},     {1'b0, 2'd3, 4'd10, `SC_4},
        {1'b0, 2'd0, 4'd11, `SC_5},     {1'b0, 2'd1, 4'd11, `SC_6},
        {1'b0, 2'd2, 4'd11, `SC_7},     {1'b0, 2'd3, 4'd11, `SC_8}
    };

    logic                           clk_sys;
    logic                           rst_n;
    arcade_input_pkg::ps2_key_t     ps2_key;
    arcade_input_pkg::joy_word_t    joy [`NUM_PLAYERS];
    logic                           osd_pause_en;
    logic                           osd_status;
    logic                           ioctl_wr;
    logic [7:0]                     ioctl_index;
    logic [24:0]                    ioctl_addr;
    arcade_input_pkg::dip_byte_t    ioctl_dout;
    arcade_input_pkg::player_ctrl_t ctrl [`NUM_PLAYERS];
    logic [`NUM_PLAYERS-1:0]        start;
    logic [`NUM_PLAYERS-1:0]        coin;
    logic                           pause_cpu;
    arcade_input_pkg::dip_bank_t    dip_sw;

    // Reference model state
    logic [11:0]                    kb_m [`NUM_PLAYERS];
    logic                           pause_m;
    arcade_input_pkg::dip_bank_t    dip_m;
    int                             errors;
    int                             checks;
    int                             assert_fails;
    int                             cycles = 0;

    arcade_input_top u_arcade_input_top (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .ps2_key      (ps2_key),
        .joystick_p1  (joy[0]),
        .joystick_p2  (joy[1]),
        .joystick_p3  (joy[2]),
        .joystick_p4  (joy[3]),
        .osd_pause_en (osd_pause_en),
        .osd_status   (osd_status),
        .ioctl_wr     (ioctl_wr),
        .ioctl_index  (ioctl_index),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .controls_p1  (ctrl[0]),
        .controls_p2  (ctrl[1]),
        .controls_p3  (ctrl[2]),
        .controls_p4  (ctrl[3]),
        .start        (start),
        .coin         (coin),
        .pause_cpu    (pause_cpu),
        .dip_sw       (dip_sw)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Model helpers and checks
    //////////////////////////////////////////////////
    function automatic logic pause_held();
        logic held;
        held = 1'b0;
        for (int p = 0; p < `NUM_PLAYERS; p++) begin
            held = held | joy[p][`JOY_PAUSE_BIT];
        end
        return held;
    endfunction

    task automatic check_value(input string name, input logic [23:0] exp,
                               input logic [23:0] act);
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Let the pipeline settle, then compare on the falling edge
    task automatic settle_and_check(input string name);
        logic [`NUM_PLAYERS-1:0] exp_start;
        logic [`NUM_PLAYERS-1:0] exp_coin;
        logic                    alt_any;
        alt_any = 1'b0;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        for (int p = 0; p < `NUM_PLAYERS; p++) begin
            check_value($sformatf("%s controls_p%0d", name, p + 1),
                        kb_m[p][9:0] | joy[p][9:0], ctrl[p]);
            exp_start[p] = kb_m[p][10] | joy[p][`JOY_START_BIT];
            exp_coin[p]  = kb_m[p][11] | joy[p][`JOY_COIN_BIT];
            alt_any      = alt_any | joy[p][`JOY_START2_ALT_BIT];
        end
        exp_start[1] = exp_start[1] | alt_any;
        check_value({name, " start"}, exp_start, start);
        check_value({name, " coin"}, exp_coin, coin);
        check_value({name, " pause_cpu"}, pause_m | (osd_pause_en & osd_status), pause_cpu);
        check_value({name, " dip_sw"}, dip_m, dip_sw);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    // Words packed as {p4, p3, p2, p1}
    task automatic drive_joysticks(input logic [63:0] words);
        logic new_any;
        new_any = 1'b0;
        @(posedge clk_sys);
        for (int p = 0; p < `NUM_PLAYERS; p++) begin
            new_any = new_any | words[16*p + `JOY_PAUSE_BIT];
        end
        if (new_any && !pause_held()) begin
            pause_m = ~pause_m;
        end
        for (int p = 0; p < `NUM_PLAYERS; p++) begin
            joy[p] <= words[16*p +: 16];
        end
    endtask

    task automatic send_key(input logic ext, input logic pressed, input logic [7:0] code);
        logic [14:0] ent;
        @(posedge clk_sys);
        ps2_key <= {~ps2_key[10], pressed, ext, code};
        if (!ext && code == `SC_P && pressed && !pause_held()) begin
            pause_m = ~pause_m;
        end
        for (int k = 0; k < 20; k++) begin
            ent = KEY_MAP[k];
            if (ent[14] == ext && ent[7:0] == code) begin
                kb_m[ent[13:12]][ent[11:8]] = pressed;
            end
        end
    endtask

    task automatic set_osd(input logic en, input logic status);
        @(posedge clk_sys);
        osd_pause_en <= en;
        osd_status   <= status;
    endtask

    task automatic write_dip(input logic [7:0] index, input int addr, input logic [7:0] data);
        @(posedge clk_sys);
        ioctl_wr    <= 1'b1;
        ioctl_index <= index;
        ioctl_addr  <= 25'(addr);
        ioctl_dout  <= data;
        @(posedge clk_sys);
        ioctl_wr <= 1'b0;
        if (index == `DIP_INDEX && addr < `NUM_DIP_BYTES) begin
            dip_m[8*addr +: 8] = data;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h3c6e_3dfb));
        rst_n        = 1'b0;
        ps2_key      = '0;
        osd_pause_en = 1'b0;
        osd_status   = 1'b0;
        ioctl_wr     = 1'b0;
        ioctl_index  = '0;
        ioctl_addr   = '0;
        ioctl_dout   = '0;
        for (int p = 0; p < `NUM_PLAYERS; p++) begin
            joy[p]  = '0;
            kb_m[p] = '0;
        end
        pause_m = 1'b0;
        dip_m   = '1;
        errors  = 0;
        checks  = 0;
        repeat (5) @(posedge clk_sys);
        rst_n <= 1'b1;
        settle_and_check("reset");

        repeat (100) begin
            drive_joysticks({$urandom, $urandom});
            settle_and_check("joystick_random");
        end
        // Alternate start on player 3 only
        drive_joysticks(64'h0000_1000_0000_0000);
        settle_and_check("start2_alias");
        drive_joysticks('0);
        settle_and_check("joystick_clear");

        for (int k = 0; k < 20; k++) begin
            send_key(KEY_MAP[k][14], 1'b1, KEY_MAP[k][7:0]);
            settle_and_check("key_press");
            send_key(KEY_MAP[k][14], 1'b0, KEY_MAP[k][7:0]);
            settle_and_check("key_release");
        end
        send_key(1'b0, 1'b1, 8'h5a);
        settle_and_check("unmapped_key");
        // Right Ctrl is the extended form of left Ctrl
        send_key(1'b1, 1'b1, `SC_LCTRL);
        settle_and_check("unmapped_extended");
        send_key(1'b1, 1'b1, `SC_UP);
        drive_joysticks(64'h0008);
        settle_and_check("key_and_joystick");
        send_key(1'b1, 1'b0, `SC_UP);
        settle_and_check("key_release_joystick_held");
        drive_joysticks('0);
        settle_and_check("joystick_release");

        for (int n = 0; n < 2; n++) begin
            send_key(1'b0, 1'b1, `SC_P);
            settle_and_check("pause_key_press");
            send_key(1'b0, 1'b0, `SC_P);
            settle_and_check("pause_key_release");
        end
        drive_joysticks(64'h2000_0000);
        settle_and_check("pause_joystick_p2");
        settle_and_check("pause_joystick_hold");
        drive_joysticks('0);
        settle_and_check("pause_joystick_drop");
        drive_joysticks(64'h2000_0000_0000_0000);
        settle_and_check("pause_joystick_p4");
        drive_joysticks('0);
        settle_and_check("pause_joystick_drop");
        if (pause_m) begin
            send_key(1'b0, 1'b1, `SC_P);
            send_key(1'b0, 1'b0, `SC_P);
            settle_and_check("pause_clear");
        end
        set_osd(1'b1, 1'b1);
        settle_and_check("osd_force");
        set_osd(1'b1, 1'b0);
        settle_and_check("osd_release");
        set_osd(1'b0, 1'b1);
        settle_and_check("osd_disabled");
        set_osd(1'b0, 1'b0);

        write_dip(`DIP_INDEX, 0, 8'h5a);
        settle_and_check("dip_byte0");
        write_dip(`DIP_INDEX, 1, 8'hc3);
        settle_and_check("dip_byte1");
        write_dip(`DIP_INDEX, 2, 8'h0f);
        settle_and_check("dip_byte2");
        write_dip(8'd253, 0, 8'h00);
        settle_and_check("dip_other_index");
        write_dip(`DIP_INDEX, 3, 8'h00);
        settle_and_check("dip_addr3");
        write_dip(`DIP_INDEX, 7, 8'h00);
        settle_and_check("dip_addr7");

        assert_fails = u_arcade_input_top.u_arcade_input_assert.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/arcade_input_pkg.sv
src/ps2_key_decoder.sv
src/player_input_slice.sv
src/control_collector.sv
src/dip_switch_bank.sv
src/arcade_input_top.sv
verif/arcade_input_assert.sv
verif/arcade_input_tb.sv

// ==== Bender.yml ====
package:
  name: arcade_input

sources:
  - include_dirs:
      - include
    files:
      - src/arcade_input_pkg.sv
      - src/ps2_key_decoder.sv
      - src/player_input_slice.sv
      - src/control_collector.sv
      - src/dip_switch_bank.sv
      - src/arcade_input_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/arcade_input_assert.sv
      - verif/arcade_input_tb.sv
